//--- lookup_pkg.sv
`default_nettype none

package lookup_pkg;

    // Datapath widths
    localparam int KEY_W  = 24;
    localparam int ACT_W  = 32;
    localparam int PHV_W  = 32;
    localparam int CTRL_W = 64;
    localparam int IDX_W  = 4;

    // Emitted when no CAM entry matches the key
    localparam logic [ACT_W-1:0] DEFAULT_ACTION = ACT_W'('h3F);

    // Header flag that marks a table configuration packet
    localparam logic [15:0] CFG_MAGIC = 16'hF2F1;

    // Header fields take 8 + 4 + 16 + 8 bits at the top of the beat
    localparam int HDR_PAD_W = CTRL_W - 36;

    // One control beat, read either as a packet header or as a table entry
    typedef union packed {
        struct packed {
            logic [7:0]           mod_id;
            logic [3:0]           resv;
            logic [15:0]          control_flag;
            logic [7:0]           index;
            logic [HDR_PAD_W-1:0] pad;
        } hdr;
        struct packed {
            logic [CTRL_W-ACT_W-1:0] pad;
            // CAM entries use the low KEY_W bits only
            logic [ACT_W-1:0]        data;
        } ent;
    } ctrl_beat_t;

endpackage

`default_nettype wire

//--- cfg_write_if.sv
`default_nettype none

interface cfg_write_if
    import lookup_pkg::*;
();

    // Single-cycle write strobes, one per table
    logic             cam_we;
    logic             act_we;

    // Shared entry address
    logic [IDX_W-1:0] index;

    logic [KEY_W-1:0] cam_data;
    logic [ACT_W-1:0] act_data;

    modport ctrl (
        output cam_we, act_we, index, cam_data, act_data
    );

    modport cam (
        input cam_we, index, cam_data
    );

    modport act (
        input act_we, index, act_data
    );

endinterface

`default_nettype wire

//--- cfg_decoder.sv
`default_nettype none

module cfg_decoder
    import lookup_pkg::*;
#(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd0
) (
    input  wire              clk,
    input  wire              rst_n,

    input  wire ctrl_beat_t  c_s_tdata,
    input  wire              c_s_tvalid,
    input  wire              c_s_tlast,

    output ctrl_beat_t       c_m_tdata,
    output logic             c_m_tvalid,
    output logic             c_m_tlast,

    cfg_write_if.ctrl        wr
);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_WRITE   = 2'd1;
    localparam logic [1:0] S_FORWARD = 2'd2;

    logic [1:0]       state;
    logic             tgt_act;
    logic [IDX_W-1:0] cur_idx;
    logic             hdr_match;
    logic             wr_beat;
    logic             fwd_beat;

    // Header addressed to this stage and lookup table
    assign hdr_match = (c_s_tdata.hdr.mod_id[7:3] == STAGE_ID) &&
                       (c_s_tdata.hdr.mod_id[2:0] == LOOKUP_ID) &&
                       (c_s_tdata.hdr.control_flag == CFG_MAGIC);

    // Foreign header, or any beat of a packet already being passed on
    assign fwd_beat = c_s_tvalid &&
                      (((state == S_IDLE) && !hdr_match) || (state == S_FORWARD));

    // Entry beat of a configuration packet
    assign wr_beat = c_s_tvalid && (state == S_WRITE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            tgt_act <= 1'b0;
            cur_idx <= '0;
        end else if (c_s_tvalid) begin
            case (state)
                S_IDLE: begin
                    if (hdr_match) begin
                        // resv of zero selects the CAM, anything else the actions
                        tgt_act <= (c_s_tdata.hdr.resv != 4'd0);
                        cur_idx <= c_s_tdata.hdr.index[IDX_W-1:0];
                        if (!c_s_tlast) begin
                            state <= S_WRITE;
                        end
                    end else if (!c_s_tlast) begin
                        state <= S_FORWARD;
                    end
                end
                S_WRITE: begin
                    // Consecutive entries go to consecutive indices
                    cur_idx <= cur_idx + IDX_W'(1);
                    if (c_s_tlast) begin
                        state <= S_IDLE;
                    end
                end
                S_FORWARD: begin
                    if (c_s_tlast) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Strobes and stream qualifiers, one cycle behind the input beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.cam_we  <= 1'b0;
            wr.act_we  <= 1'b0;
            c_m_tvalid <= 1'b0;
            c_m_tlast  <= 1'b0;
        end else begin
            wr.cam_we  <= wr_beat && !tgt_act;
            wr.act_we  <= wr_beat && tgt_act;
            c_m_tvalid <= fwd_beat;
            c_m_tlast  <= fwd_beat && c_s_tlast;
        end
    end

    // Payload, only meaningful alongside the strobes above
    always_ff @(posedge clk) begin
        if (wr_beat) begin
            wr.index    <= cur_idx;
            wr.cam_data <= c_s_tdata.ent.data[KEY_W-1:0];
            wr.act_data <= c_s_tdata.ent.data;
        end
        if (fwd_beat) begin
            c_m_tdata <= c_s_tdata;
        end
    end

endmodule

`default_nettype wire

//--- key_cam.sv
`default_nettype none

module key_cam
    import lookup_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire              clk,
    input  wire              rst_n,

    input  wire              key_valid,
    input  wire [KEY_W-1:0]  key,

    cfg_write_if.cam         wr,

    output logic             stage1_valid,
    output logic             hit,
    output logic [IDX_W-1:0] match_idx
);

    logic [KEY_W-1:0] cam_mem [DEPTH];
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] match_vec;
    logic [IDX_W-1:0] first_idx;

    always_ff @(posedge clk) begin
        if (wr.cam_we) begin
            cam_mem[wr.index] <= wr.cam_data;
        end
    end

    // An entry takes part in matching once it has been written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr.cam_we) begin
            entry_valid[wr.index] <= 1'b1;
        end
    end

    // Exact compare against every entry in parallel
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            match_vec[i] = entry_valid[i] && (cam_mem[i] == key);
        end
    end

    // Lowest matching index wins
    always_comb begin
        first_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                first_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
            hit          <= 1'b0;
        end else begin
            stage1_valid <= key_valid;
            hit          <= |match_vec;
        end
    end

    always_ff @(posedge clk) begin
        match_idx <= first_idx;
    end

endmodule

`default_nettype wire

//--- action_table.sv
`default_nettype none

module action_table
    import lookup_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire              clk,

    // Read address from the CAM stage
    input  wire [IDX_W-1:0]  match_idx,

    cfg_write_if.act         wr,

    output logic [ACT_W-1:0] rd_action
);

    logic [ACT_W-1:0] act_mem [DEPTH];

    // Write port from the control path
    always_ff @(posedge clk) begin
        if (wr.act_we) begin
            act_mem[wr.index] <= wr.act_data;
        end
    end

    // Read every cycle; a miss is filtered out downstream
    always_ff @(posedge clk) begin
        rd_action <= act_mem[match_idx];
    end

endmodule

`default_nettype wire

//--- action_select.sv
`default_nettype none

module action_select
    import lookup_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire              key_valid,
    input  wire [PHV_W-1:0]  phv_in,

    // From the CAM stage
    input  wire              stage1_valid,
    input  wire              hit,

    // From the action memory, one cycle after the CAM stage
    input  wire [ACT_W-1:0]  rd_action,

    output logic             action_valid,
    output logic [ACT_W-1:0] action,
    output logic [PHV_W-1:0] phv_out
);

    logic [PHV_W-1:0] phv_d1;
    logic [PHV_W-1:0] phv_d2;
    logic             valid_d2;
    logic             hit_d2;

    // PHV rides along with the key through both stages
    always_ff @(posedge clk) begin
        if (key_valid) begin
            phv_d1 <= phv_in;
        end
        phv_d2 <= phv_d1;
    end

    // Line up hit and valid with the registered action read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d2 <= 1'b0;
            hit_d2   <= 1'b0;
        end else begin
            valid_d2 <= stage1_valid;
            hit_d2   <= hit;
        end
    end

    assign action_valid = valid_d2;
    assign action       = hit_d2 ? rd_action : DEFAULT_ACTION;
    assign phv_out      = phv_d2;

endmodule

`default_nettype wire

//--- lookup_engine.sv
`default_nettype none

module lookup_engine
    import lookup_pkg::*;
#(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd0,
    parameter int         DEPTH     = 16
) (
    input  wire               clk,
    input  wire               rst_n,

    // Lookup request
    input  wire               key_valid,
    input  wire [KEY_W-1:0]   key,
    input  wire [PHV_W-1:0]   phv_in,

    // Lookup result
    output logic              action_valid,
    output logic [ACT_W-1:0]  action,
    output logic [PHV_W-1:0]  phv_out,

    // Control stream in
    input  wire [CTRL_W-1:0]  c_s_tdata,
    input  wire               c_s_tvalid,
    input  wire               c_s_tlast,

    // Control stream out, foreign packets only
    output logic [CTRL_W-1:0] c_m_tdata,
    output logic              c_m_tvalid,
    output logic              c_m_tlast
);

    logic             stage1_valid;
    logic             hit;
    logic [IDX_W-1:0] match_idx;
    logic [ACT_W-1:0] rd_action;

    cfg_write_if cfg_wr ();

    cfg_decoder #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) cfg_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_s_tdata  (c_s_tdata),
        .c_s_tvalid (c_s_tvalid),
        .c_s_tlast  (c_s_tlast),
        .c_m_tdata  (c_m_tdata),
        .c_m_tvalid (c_m_tvalid),
        .c_m_tlast  (c_m_tlast),
        .wr         (cfg_wr)
    );

    key_cam #(
        .DEPTH (DEPTH)
    ) key_cam_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key          (key),
        .wr           (cfg_wr),
        .stage1_valid (stage1_valid),
        .hit          (hit),
        .match_idx    (match_idx)
    );

    action_table #(
        .DEPTH (DEPTH)
    ) action_table_i (
        .clk       (clk),
        .match_idx (match_idx),
        .wr        (cfg_wr),
        .rd_action (rd_action)
    );

    action_select action_select_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .stage1_valid (stage1_valid),
        .hit          (hit),
        .rd_action    (rd_action),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out)
    );

endmodule

`default_nettype wire

//--- lookup_engine_assertions.sv
`default_nettype none

module lookup_engine_assertions
    import lookup_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire key_valid,
    input wire action_valid,
    input wire c_s_tvalid,
    input wire c_m_tvalid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Every key produces a result two cycles on
    assert property (@(posedge clk) disable iff (!rst_n) key_valid |-> ##2 action_valid)
        else $error("lookup result missing two cycles after key_valid");

    // And no result appears without a key
    assert property (@(posedge clk) disable iff (!rst_n) action_valid |-> $past(key_valid, 2))
        else $error("action_valid without a key two cycles earlier");

    // Forwarded beats always follow an input beat
    assert property (@(posedge clk) disable iff (!rst_n) c_m_tvalid |-> $past(c_s_tvalid))
        else $error("c_m_tvalid without an input beat one cycle earlier");

    assert property (@(posedge clk) disable iff (!rst_n)
                     !$isunknown(action_valid) && !$isunknown(c_m_tvalid))
        else $error("output valid is unknown after reset");

endmodule

bind lookup_engine lookup_engine_assertions assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_valid    (key_valid),
    .action_valid (action_valid),
    .c_s_tvalid   (c_s_tvalid),
    .c_m_tvalid   (c_m_tvalid)
);

`default_nettype wire

//--- tb_lookup_engine.sv
`default_nettype none

module tb_lookup_engine
    import lookup_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst_n;
    logic              key_valid;
    logic [KEY_W-1:0]  key;
    logic [PHV_W-1:0]  phv_in;
    logic              action_valid;
    logic [ACT_W-1:0]  action;
    logic [PHV_W-1:0]  phv_out;
    logic [CTRL_W-1:0] c_s_tdata;
    logic              c_s_tvalid;
    logic              c_s_tlast;
    logic [CTRL_W-1:0] c_m_tdata;
    logic              c_m_tvalid;
    logic              c_m_tlast;

    // Expected results in the order they must appear
    logic [ACT_W-1:0]  exp_act_q[$];
    logic [PHV_W-1:0]  exp_phv_q[$];
    int                exp_cycle_q[$];
    logic [CTRL_W:0]   exp_beat_q[$];
    int                exp_beat_cycle_q[$];

    int     cycle = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    integer seed;

    lookup_engine #(
        .STAGE_ID  (5'd2),
        .LOOKUP_ID (3'd3),
        .DEPTH     (16)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key          (key),
        .phv_in       (phv_in),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out),
        .c_s_tdata    (c_s_tdata),
        .c_s_tvalid   (c_s_tvalid),
        .c_s_tlast    (c_s_tlast),
        .c_m_tdata    (c_m_tdata),
        .c_m_tvalid   (c_m_tvalid),
        .c_m_tlast    (c_m_tlast)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_lookup(input logic [KEY_W-1:0] k, input logic [ACT_W-1:0] a);
        logic [PHV_W-1:0] p;
        p = $random(seed);
        key_valid = 1'b1;
        key       = k;
        phv_in    = p;
        // Sampled at the next edge and visible two edges later
        exp_act_q.push_back(a);
        exp_phv_q.push_back(p);
        exp_cycle_q.push_back(cycle + 2);
        step_cycle();
        key_valid = 1'b0;
    endtask

    task automatic drive_beat(input logic [CTRL_W-1:0] d, input int last, input int fwd);
        c_s_tvalid = 1'b1;
        c_s_tdata  = d;
        c_s_tlast  = (last != 0);
        if (fwd != 0) begin
            // Forwarded beat shows up one edge after it is sampled
            exp_beat_q.push_back({(last != 0), d});
            exp_beat_cycle_q.push_back(cycle + 1);
        end
        step_cycle();
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
    endtask

    // Let every outstanding result come out before reporting the test
    task automatic finish_test(input int num);
        int waited;
        waited = 0;
        while ((exp_act_q.size() != 0 || exp_beat_q.size() != 0) && waited < 50) begin
            step_cycle();
            waited++;
        end
        if (exp_act_q.size() != 0 || exp_beat_q.size() != 0) begin
            report_failure($sformatf("timeout: %0d lookups and %0d forwarded beats never appeared",
                                     exp_act_q.size(), exp_beat_q.size()));
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d finished: passed", num);
        end else begin
            $display("test %0d finished: FAILED with %0d errors", num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    always @(negedge clk) begin : check_outputs
        logic [ACT_W-1:0] e_act;
        logic [PHV_W-1:0] e_phv;
        int               e_cycle;
        logic [CTRL_W:0]  e_beat;
        int               e_beat_cycle;
        if (rst_n && action_valid === 1'b1) begin
            if (exp_act_q.size() == 0) begin
                report_failure("action_valid rose with no lookup outstanding");
            end else begin
                e_act   = exp_act_q.pop_front();
                e_phv   = exp_phv_q.pop_front();
                e_cycle = exp_cycle_q.pop_front();
                checks++;
                if (action !== e_act) begin
                    report_mismatch($sformatf("action %h, expected %h", action, e_act));
                end
                if (phv_out !== e_phv) begin
                    report_mismatch($sformatf("phv_out %h, expected %h", phv_out, e_phv));
                end
                if (cycle != e_cycle) begin
                    report_mismatch($sformatf("result in cycle %0d, expected %0d", cycle, e_cycle));
                end
            end
        end
        if (rst_n && c_m_tvalid === 1'b1) begin
            if (exp_beat_q.size() == 0) begin
                report_failure("c_m_tvalid rose for a beat that should have been consumed");
            end else begin
                e_beat       = exp_beat_q.pop_front();
                e_beat_cycle = exp_beat_cycle_q.pop_front();
                checks++;
                if ({c_m_tlast, c_m_tdata} !== e_beat) begin
                    report_mismatch($sformatf("forwarded beat %b %h, expected %b %h",
                                              c_m_tlast, c_m_tdata,
                                              e_beat[CTRL_W], e_beat[CTRL_W-1:0]));
                end
                if (cycle != e_beat_cycle) begin
                    report_mismatch($sformatf("beat in cycle %0d, expected %0d",
                                              cycle, e_beat_cycle));
                end
            end
        end
    end

    initial begin : main
        int                fd;
        int                code;
        int                n;
        int                last;
        int                fwd;
        int                test_num;
        logic [7:0]        op;
        logic [8*128-1:0]  line;
        logic [CTRL_W-1:0] beat;
        logic [KEY_W-1:0]  k;
        logic [ACT_W-1:0]  a;
        test_num   = 0;
        seed       = 32'he8d52876;
        clk        = 1'b0;
        rst_n      = 1'b0;
        key_valid  = 1'b0;
        key        = '0;
        phv_in     = '0;
        c_s_tdata  = '0;
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("lookup_engine_golden.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open lookup_engine_golden.txt");
        end else begin
            code = $fscanf(fd, " %c", op);
            while (code == 1) begin
                case (op)
                    "#": code = $fgets(line, fd);
                    "T": begin
                        // A new test closes the previous one
                        if (test_num != 0) begin
                            finish_test(test_num);
                        end
                        code = $fscanf(fd, "%d", test_num);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %d %d", beat, last, fwd);
                        drive_beat(beat, last, fwd);
                    end
                    "L": begin
                        code = $fscanf(fd, "%h %h", k, a);
                        drive_lookup(k, a);
                    end
                    "I": begin
                        code = $fscanf(fd, "%d", n);
                        repeat (n) step_cycle();
                    end
                    default: report_failure($sformatf("unknown operation %c in golden file", op));
                endcase
                code = $fscanf(fd, " %c", op);
            end
            if (test_num != 0) begin
                finish_test(test_num);
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lookup_engine.f
lookup_pkg.sv
cfg_write_if.sv
cfg_decoder.sv
key_cam.sv
action_table.sv
action_select.sv
lookup_engine.sv
lookup_engine_assertions.sv
tb_lookup_engine.sv

//--- lookup_engine_golden.txt
# C <beat hex> <last> <forwarded>   L <key hex> <expected action hex>, PHV is random
# I <idle cycles>   T <test number>   header: mod_id 13, resv, magic F2F1, index
T 1
L A1B2C3 0000003F
L 112233 0000003F
L 000000 0000003F
T 2
# CAM entries at index 4 to 6, then their actions
C 130F2F1040000000 0 0
C 0000000000A1B2C3 0 0
C 0000000000112233 0 0
C 0000000000445566 1 0
C 131F2F1040000000 0 0
C 0000000080000004 0 0
C 0000000080000005 0 0
C 0000000080000006 1 0
I 2
L A1B2C3 80000004
L 445566 80000006
L 112233 80000005
T 3
# Index 9 holds the same key as index 5
C 130F2F1090000000 0 0
C 0000000000112233 1 0
C 131F2F1090000000 0 0
C 0000000080000009 1 0
I 2
L 112233 80000005
T 4
L 112233 80000005
L A1B2C3 80000004
L 999999 0000003F
L 445566 80000006
L A1B2C3 80000004
T 5
# Wrong module id, wrong magic, wrong lookup id
C 140F2F1040000000 0 1
C 0000000000CAFE01 1 1
C 130F2F2050000000 0 1
C 0000000000CAFE02 1 1
C 120F2F1000000000 1 1
I 2
L CAFE01 0000003F
L CAFE02 0000003F
T 6
C 130F2F1040000000 0 0
C 0000000000BEEF01 1 0
I 2
L A1B2C3 0000003F
L BEEF01 80000004
